// ==== logic/c16_glue_pkg.sv ====
package c16_glue_pkg;

	////////////////////////////////////////////////////////////
	// Bus bundles

	// Host download stream
	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_bus_t;

	// CPU side, selects are active low
	typedef struct packed {
		logic [15:0] addr;
		logic        rnw;
		logic        cs_ram_n;
		logic        cs0_n;
		logic        cs1_n;
		logic        cs_io_n;
	} cpu_bus_t;

	typedef struct packed {
		logic        we;
		logic [15:0] addr;
		logic [7:0]  data;
	} ram_wr_t;

	// Request to the external tape memory
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} tape_mem_req_t;

	////////////////////////////////////////////////////////////
	// ROM banking

	typedef struct packed {
		logic [1:0] romh;
		logic [1:0] roml;
	} bank_sel_t;

	// Loaded from the low address nibble, read back as two selects
	typedef union packed {
		logic [3:0] raw;
		bank_sel_t  sel;
	} bank_reg_u;

	typedef enum logic [2:0] {
		SRC_NONE,
		SRC_RAM,
		SRC_BASIC,
		SRC_KERNAL,
		SRC_FUNC_LO,
		SRC_FUNC_HI,
		SRC_CART_LO,
		SRC_CART_HI
	} rom_src_t;

	////////////////////////////////////////////////////////////
	// Constants

	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_PRG  = 8'd1;
	localparam logic [7:0] IDX_CART = 8'd2;
	localparam logic [7:0] IDX_TAP  = 8'd4;

	// BASIC end pointers, patched after a PRG load
	localparam logic [15:0] PRG_POINTERS [0:7] = '{
		16'h002d, 16'h002e, 16'h002f, 16'h0030,
		16'h0031, 16'h0032, 16'h009d, 16'h009e
	};

	localparam logic [11:0] BANK_REG_PAGE    = 12'hFDD;
	localparam logic [7:0]  KERNAL_PAGE      = 8'hFC;
	localparam int          CART_CHUNK_SHIFT = 14;

	localparam logic [31:0] SYS_HZ_PAL  = 32'd56750336;
	localparam logic [31:0] SYS_HZ_NTSC = 32'd57272720;
	localparam logic [31:0] DRIVE_HZ    = 32'd32000000;

	localparam int LED_CNT_W = 27;

endpackage

// ==== logic/prg_loader.sv ====
`timescale 1ns/1ps

module prg_loader import c16_glue_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  dl_bus_t dl_i,
	output ram_wr_t ram_wr_o
);

	ram_wr_t     wr_q;
	logic [15:0] load_addr_q;
	logic [3:0]  seq_q;
	logic        active_q;

	logic        prg_sel;
	logic        prg_busy;
	logic        prg_end;

	assign prg_sel  = (dl_i.index == IDX_PRG);
	assign prg_busy = prg_sel && dl_i.active;

	// First cycle with the download seen low
	assign prg_end = prg_sel && active_q && !dl_i.active;

	assign ram_wr_o = wr_q;

	////////////////////////////////////////////////////////////
	// Byte stream and pointer patch

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q.we  <= 1'b0;
			seq_q    <= '0;
			active_q <= 1'b0;
		end else begin
			active_q <= dl_i.active;
			wr_q.we  <= 1'b0;

			if (prg_busy && dl_i.wr) begin
				// Two header bytes carry the load address
				if (dl_i.addr == 25'd0) begin
					load_addr_q[7:0] <= dl_i.data;
				end else if (dl_i.addr == 25'd1) begin
					load_addr_q[15:8] <= dl_i.data;
				end else begin
					wr_q.we     <= 1'b1;
					wr_q.addr   <= load_addr_q;
					wr_q.data   <= dl_i.data;
					load_addr_q <= load_addr_q + 16'd1;
				end
			end

			// Sequence runs 1..15 and wraps back to idle
			if (prg_end) begin
				seq_q <= 4'd1;
			end else if (prg_busy) begin
				seq_q <= '0;
			end else if (seq_q != 4'd0) begin
				seq_q <= seq_q + 4'd1;
			end

			// Odd steps write, low byte first, then high byte
			if (seq_q[0]) begin
				wr_q.we   <= 1'b1;
				wr_q.addr <= PRG_POINTERS[seq_q[3:1]];
				if (seq_q[1]) begin
					wr_q.data <= load_addr_q[15:8];
				end else begin
					wr_q.data <= load_addr_q[7:0];
				end
			end
		end
	end

endmodule

// ==== logic/rom_bank_map.sv ====
`timescale 1ns/1ps

module rom_bank_map import c16_glue_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     cpu_ce_i,
	input  logic     model_plus4_i,
	input  dl_bus_t  dl_i,
	input  cpu_bus_t cpu_i,
	output rom_src_t rom_src_o,
	output logic     core_reset_o
);

	logic      model_q;
	logic      cs_io_q;
	bank_reg_u bank_q;
	logic      cart_lo_q;
	logic      cart_hi_q;

	logic      cart_sel;
	logic      cart_wr;
	logic      bank_wr;
	logic      kern_page;

	assign cart_sel = (dl_i.index == IDX_CART);
	assign cart_wr  = cart_sel && dl_i.wr;

	// Plus-4 holds the core in reset while a cartridge loads
	assign core_reset_o = reset || (model_q && cart_sel && dl_i.active);

	// IO write to the bank page completes when cs_io_n goes back high
	assign bank_wr = cpu_ce_i && !cs_io_q && cpu_i.cs_io_n && !cpu_i.rnw &&
		(cpu_i.addr[15:4] == BANK_REG_PAGE) && model_q;

	assign kern_page = (cpu_i.addr[15:8] == KERNAL_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model_plus4_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Bank register

	always_ff @(posedge clk_sys) begin
		if (core_reset_o) begin
			bank_q.raw <= '0;
			cs_io_q    <= 1'b1;
		end else if (cpu_ce_i) begin
			cs_io_q <= cpu_i.cs_io_n;
			if (bank_wr) begin
				bank_q.raw <= cpu_i.addr[3:0];
			end
		end
	end

	// Cartridge halves present
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
		end else if (cart_wr) begin
			if (dl_i.addr[CART_CHUNK_SHIFT]) begin
				cart_hi_q <= 1'b1;
			end else begin
				cart_lo_q <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read source

	always_comb begin
		rom_src_o = SRC_NONE;
		if (!cpu_i.cs_ram_n) begin
			rom_src_o = SRC_RAM;
		end else if (!cpu_i.cs0_n) begin
			case (bank_q.sel.roml)
				2'd0: rom_src_o = SRC_BASIC;
				2'd1: rom_src_o = cart_lo_q ? SRC_CART_LO : SRC_NONE;
				2'd2: rom_src_o = SRC_FUNC_LO;
				default: rom_src_o = SRC_NONE;
			endcase
		end else if (!cpu_i.cs1_n) begin
			// Kernal page stays visible whatever the bank
			if (kern_page || bank_q.sel.romh == 2'd0) begin
				rom_src_o = SRC_KERNAL;
			end else if (bank_q.sel.romh == 2'd1) begin
				rom_src_o = cart_hi_q ? SRC_CART_HI : SRC_NONE;
			end else if (bank_q.sel.romh == 2'd2) begin
				rom_src_o = SRC_FUNC_HI;
			end
		end
	end

endmodule

// ==== logic/tape_streamer.sv ====
`timescale 1ns/1ps

module tape_streamer import c16_glue_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          play_btn_i,
	input  dl_bus_t       dl_i,
	output logic          dl_wait_o,
	output tape_mem_req_t mem_req_o,
	input  logic          mem_ready_i,
	input  logic [7:0]    mem_data_i,
	input  logic          fifo_full_i,
	input  logic          fifo_empty_i,
	output logic          fifo_wrreq_o,
	output logic [7:0]    fifo_data_o,
	output logic          tape_restart_o,
	output logic          tape_led_o
);

	tape_mem_req_t        req_q;
	logic                 dl_wait_q;
	logic [24:0]          play_addr_q;
	logic [24:0]          last_addr_q;
	logic                 playing_q;
	logic                 cycle_q;
	logic                 btn_q;
	logic                 active_q;
	logic                 restart_q;
	logic                 wrreq_q;
	logic [7:0]           fifo_data_q;
	logic [LED_CNT_W-1:0] act_cnt_q;

	logic       tap_sel;
	logic       tap_busy;
	logic       loaded;
	logic       read_start;
	logic       read_done;
	logic [7:0] led_phase;

	assign tap_sel    = (dl_i.index == IDX_TAP);
	assign tap_busy   = tap_sel && dl_i.active;
	assign loaded     = (play_addr_q < last_addr_q);
	assign read_start = !cycle_q && playing_q && loaded && !fifo_full_i && !tap_busy;
	assign read_done  = cycle_q && !req_q.rd && mem_ready_i;

	assign mem_req_o      = req_q;
	assign dl_wait_o      = dl_wait_q;
	assign fifo_wrreq_o   = wrreq_q;
	assign fifo_data_o    = fifo_data_q;
	assign tape_restart_o = restart_q;

	////////////////////////////////////////////////////////////
	// Memory requests

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_q.rd  <= 1'b0;
			req_q.wr  <= 1'b0;
			dl_wait_q <= 1'b0;
		end else begin
			req_q.rd <= 1'b0;
			req_q.wr <= 1'b0;
			if (tap_sel && dl_i.wr) begin
				req_q.wr   <= 1'b1;
				req_q.addr <= dl_i.addr;
				req_q.data <= dl_i.data;
				dl_wait_q  <= 1'b1;
			end else if (read_start) begin
				req_q.rd   <= 1'b1;
				req_q.addr <= play_addr_q;
			end
			if (dl_wait_q && !req_q.wr && mem_ready_i) begin
				dl_wait_q <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Play control and FIFO feed

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			play_addr_q <= '0;
			last_addr_q <= '0;
			playing_q   <= 1'b0;
			cycle_q     <= 1'b0;
			btn_q       <= 1'b0;
			active_q    <= 1'b0;
			restart_q   <= 1'b1;
			wrreq_q     <= 1'b0;
		end else begin
			btn_q     <= play_btn_i;
			active_q  <= dl_i.active;
			restart_q <= 1'b0;
			wrreq_q   <= 1'b0;

			if (tap_sel && active_q && !dl_i.active) playing_q <= 1'b1;
			if (loaded && play_btn_i && !btn_q) playing_q <= !playing_q;
			if (fifo_empty_i) playing_q <= 1'b0;

			if (read_done) begin
				play_addr_q <= play_addr_q + 25'd1;
				cycle_q     <= 1'b0;
				wrreq_q     <= 1'b1;
				fifo_data_q <= mem_data_i;
			end else if (read_start) begin
				cycle_q <= 1'b1;
			end

			// A new image rewinds everything
			if (tap_busy) begin
				playing_q   <= 1'b0;
				play_addr_q <= '0;
				cycle_q     <= 1'b0;
				restart_q   <= 1'b1;
				if (dl_i.wr) last_addr_q <= dl_i.addr + 25'd1;
			end
		end
	end

	// Activity LED, a slow PWM ramp that speeds up while playing
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_cnt_q <= '0;
		end else begin
			act_cnt_q <= act_cnt_q + (playing_q ? LED_CNT_W'(8) : LED_CNT_W'(1));
		end
	end

	assign led_phase  = act_cnt_q[LED_CNT_W-2 -: 8];
	assign tape_led_o = loaded && (act_cnt_q[LED_CNT_W-1] ?
		(!playing_q && led_phase > act_cnt_q[7:0]) : (led_phase <= act_cnt_q[7:0]));

endmodule

// ==== logic/drive_clock_enable.sv ====
`timescale 1ns/1ps

module drive_clock_enable import c16_glue_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic drive_ce_o
);

	logic [31:0] acc_q;
	logic [31:0] sum;
	logic [31:0] rate;
	logic        ce_q;

	// System rate follows the video standard
	assign rate = pal_i ? SYS_HZ_PAL : SYS_HZ_NTSC;
	assign sum  = acc_q + DRIVE_HZ;

	assign drive_ce_o = ce_q;

	// Fractional divider, one pulse per rate worth of drive ticks
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc_q <= '0;
			ce_q  <= 1'b0;
		end else if (sum >= rate) begin
			acc_q <= sum - rate;
			ce_q  <= 1'b1;
		end else begin
			acc_q <= sum;
			ce_q  <= 1'b0;
		end
	end

endmodule

// ==== logic/c16_glue_top.sv ====
`timescale 1ns/1ps

module c16_glue_top import c16_glue_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          model_plus4_i,
	input  logic          pal_i,
	input  logic          play_btn_i,
	input  logic          cpu_ce_i,
	input  cpu_bus_t      cpu_i,
	input  dl_bus_t       dl_i,
	output logic          dl_wait_o,
	output ram_wr_t       ram_wr_o,
	output rom_src_t      rom_src_o,
	output logic          core_reset_o,
	output tape_mem_req_t mem_req_o,
	input  logic          mem_ready_i,
	input  logic [7:0]    mem_data_i,
	input  logic          fifo_full_i,
	input  logic          fifo_empty_i,
	output logic          fifo_wrreq_o,
	output logic [7:0]    fifo_data_o,
	output logic          tape_restart_o,
	output logic          tape_led_o,
	output logic          drive_ce_o
);

	prg_loader u_prg_loader (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_i     (dl_i),
		.ram_wr_o (ram_wr_o)
	);

	rom_bank_map u_rom_bank_map (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_ce_i      (cpu_ce_i),
		.model_plus4_i (model_plus4_i),
		.dl_i          (dl_i),
		.cpu_i         (cpu_i),
		.rom_src_o     (rom_src_o),
		.core_reset_o  (core_reset_o)
	);

	tape_streamer u_tape_streamer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.play_btn_i     (play_btn_i),
		.dl_i           (dl_i),
		.dl_wait_o      (dl_wait_o),
		.mem_req_o      (mem_req_o),
		.mem_ready_i    (mem_ready_i),
		.mem_data_i     (mem_data_i),
		.fifo_full_i    (fifo_full_i),
		.fifo_empty_i   (fifo_empty_i),
		.fifo_wrreq_o   (fifo_wrreq_o),
		.fifo_data_o    (fifo_data_o),
		.tape_restart_o (tape_restart_o),
		.tape_led_o     (tape_led_o)
	);

	drive_clock_enable u_drive_clock_enable (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_i      (pal_i),
		.drive_ce_o (drive_ce_o)
	);

endmodule

// ==== test/tb_c16_glue.sv ====
`timescale 1ns/1ps

module tb_c16_glue import c16_glue_pkg::*; ();

	// Rough cycle budget per configuration, two configurations run
	localparam int LEN_DRIVE = 2000;
	localparam int LEN_PRG   = 400;
	localparam int LEN_BANK  = 600;
	localparam int LEN_TAPE  = 1000;
	localparam int LEN_FLOW  = 3000;
	localparam int LEN_EMPTY = 1200;
	localparam int TEST_CYCLES = 2 * (LEN_DRIVE + LEN_PRG + LEN_BANK + LEN_TAPE +
		LEN_FLOW + LEN_EMPTY);
	localparam int DRIVE_N = 2000;

	logic          clk_sys = 1'b0;
	logic          reset;
	logic          model_plus4_i;
	logic          pal_i;
	logic          play_btn_i;
	logic          cpu_ce_i;
	cpu_bus_t      cpu_i;
	dl_bus_t       dl_i;
	logic          dl_wait_o;
	ram_wr_t       ram_wr_o;
	rom_src_t      rom_src_o;
	logic          core_reset_o;
	tape_mem_req_t mem_req_o;
	logic          mem_ready_i;
	logic [7:0]    mem_data_i;
	logic          fifo_full_i;
	logic          fifo_empty_i;
	logic          fifo_wrreq_o;
	logic [7:0]    fifo_data_o;
	logic          tape_restart_o;
	logic          tape_led_o;
	logic          drive_ce_o;

	integer     seed = 83954;
	int         errors = 0;
	int         tests = 0;
	int         failed = 0;
	int         drive_cnt;
	int         rd_cnt = 0;
	int         restart_cnt = 0;
	int         full_reads = 0;
	int         lat;
	logic       pend;
	logic [9:0] pend_addr;
	logic       full_rand = 1'b0;
	logic [7:0] tape_mem [0:1023];
	ram_wr_t    ram_q [$];
	logic [7:0] fifo_q [$];

	c16_glue_top i_dut (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Monitors and bus models

	always @(negedge clk_sys) begin
		if (ram_wr_o.we) ram_q.push_back(ram_wr_o);
		if (fifo_wrreq_o) fifo_q.push_back(fifo_data_o);
		if (tape_restart_o) restart_cnt++;
		if (reset) drive_cnt = 0;
		else if (drive_ce_o) drive_cnt++;
		// Read issued against the full flag the DUT last sampled
		if (mem_req_o.rd && fifo_full_i) full_reads++;
		if (full_rand) fifo_full_i = 1'($random(seed));
	end

	// Tape memory with a random ready latency, ready lasts one cycle
	always @(negedge clk_sys) begin
		if (reset) begin
			mem_ready_i = 1'b0;
			pend = 1'b0;
		end else begin
			mem_ready_i = 1'b0;
			if (mem_req_o.wr) begin
				tape_mem[mem_req_o.addr[9:0]] = mem_req_o.data;
				pend = 1'b1;
				pend_addr = 10'h3ff;
				lat = 1 + ($random(seed) & 3);
			end else if (mem_req_o.rd) begin
				rd_cnt++;
				pend = 1'b1;
				pend_addr = mem_req_o.addr[9:0];
				lat = 1 + ($random(seed) & 3);
			end else if (pend) begin
				if (lat <= 1) begin
					mem_ready_i = 1'b1;
					mem_data_i = tape_mem[pend_addr];
					pend = 1'b0;
				end else begin
					lat--;
				end
			end
		end
	end

	initial begin
		#(TEST_CYCLES * 3 / 2 * 4);
		$display("Watchdog expired, the run took longer than its test budget");
		$display("Simulation finished: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: failed", name);
		end
	endtask

	task automatic apply_reset(input logic plus4, input logic pal);
		@(negedge clk_sys);
		reset = 1'b1;
		model_plus4_i = plus4;
		pal_i = pal;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// One download byte, waits out dl_wait_o afterwards
	task automatic send_byte(input string name, input logic [7:0] idx,
		input logic [24:0] addr, input logic [7:0] data);
		dl_i.active = 1'b1;
		dl_i.index = idx;
		dl_i.addr = addr;
		dl_i.data = data;
		dl_i.wr = 1'b1;
		@(negedge clk_sys);
		// Only a tape byte holds the host off
		check_value({name, " download wait"}, 32'(idx == IDX_TAP), 32'(dl_wait_o));
		dl_i.wr = 1'b0;
		@(negedge clk_sys);
		while (dl_wait_o) @(negedge clk_sys);
	endtask

	task automatic end_download();
		dl_i.active = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic press_button();
		play_btn_i = 1'b1;
		@(negedge clk_sys);
		play_btn_i = 1'b0;
		@(negedge clk_sys);
	endtask

	// Read source from the decode rule
	function automatic rom_src_t expect_src(input cpu_bus_t c, input logic [3:0] bank,
		input logic lo, input logic hi);
		logic [1:0] roml;
		logic [1:0] romh;
		roml = bank[1:0];
		romh = bank[3:2];
		if (!c.cs_ram_n) return SRC_RAM;
		if (!c.cs0_n) begin
			if (roml == 2'd0) return SRC_BASIC;
			if (roml == 2'd1) return lo ? SRC_CART_LO : SRC_NONE;
			if (roml == 2'd2) return SRC_FUNC_LO;
			return SRC_NONE;
		end
		if (!c.cs1_n) begin
			if (c.addr[15:8] == 8'hFC || romh == 2'd0) return SRC_KERNAL;
			if (romh == 2'd1) return hi ? SRC_CART_HI : SRC_NONE;
			if (romh == 2'd2) return SRC_FUNC_HI;
		end
		return SRC_NONE;
	endfunction

	////////////////////////////////////////////////////////////
	// Tests

	task automatic drive_test(input string name, input logic pal);
		int e;
		int exp;
		longint ticks;
		e = errors;
		ticks = longint'(DRIVE_N) * 64'd32000000;
		exp = int'(ticks / (pal ? 64'd56750336 : 64'd57272720));
		cycles(DRIVE_N);
		// One pulse of slack either way
		if (drive_cnt < exp - 1 || drive_cnt > exp + 1) begin
			check_value(name, 32'(exp), 32'(drive_cnt));
		end
		report_test(name, e);
	endtask

	task automatic prg_test(input string name);
		int e;
		int n;
		int t;
		logic [15:0] load;
		logic [15:0] end_addr;
		logic [15:0] exp_addr;
		logic [7:0] bytes [$];
		logic [15:0] ptrs [0:7];
		e = errors;
		ptrs = '{16'h2d, 16'h2e, 16'h2f, 16'h30, 16'h31, 16'h32, 16'h9d, 16'h9e};
		n = 5 + ($random(seed) & 32'h7fff) % 36;
		load = 16'($random(seed));
		ram_q.delete();
		send_byte(name, IDX_PRG, 25'd0, load[7:0]);
		send_byte(name, IDX_PRG, 25'd1, load[15:8]);
		for (int i = 0; i < n; i++) begin
			bytes.push_back(8'($random(seed)));
			send_byte(name, IDX_PRG, 25'(i + 2), bytes[i]);
		end
		end_download();
		t = 0;
		while (ram_q.size() < n + 8 && t < 100) begin
			@(negedge clk_sys);
			t++;
		end
		if (ram_q.size() != n + 8) begin
			$display("%s: RAM writes missing, got %0d of %0d", name, ram_q.size(), n + 8);
			errors++;
		end else begin
			end_addr = load + 16'(n);
			for (int i = 0; i < n; i++) begin
				exp_addr = load + 16'(i);
				check_value({name, " addr"}, 32'(exp_addr), 32'(ram_q[i].addr));
				check_value({name, " data"}, 32'(bytes[i]), 32'(ram_q[i].data));
			end
			for (int k = 0; k < 8; k++) begin
				check_value({name, " ptr addr"}, 32'(ptrs[k]), 32'(ram_q[n + k].addr));
				check_value({name, " ptr data"},
					32'((k % 2 == 0) ? end_addr[7:0] : end_addr[15:8]),
					32'(ram_q[n + k].data));
			end
		end
		report_test(name, e);
	endtask

	task automatic bank_test(input string name, input logic plus4);
		int e;
		logic [3:0] bank;
		logic [3:0] nib;
		logic lo;
		logic hi;
		logic [24:0] caddr;
		e = errors;
		bank = 4'd0;
		caddr = 25'($random(seed)) & 25'h7fff;
		lo = !caddr[14];
		hi = caddr[14];
		// Cartridge half, the core is held in reset on a Plus-4
		dl_i.active = 1'b1;
		dl_i.index = IDX_CART;
		dl_i.addr = caddr;
		dl_i.wr = 1'b1;
		#1;
		check_value({name, " core reset"}, 32'(plus4), 32'(core_reset_o));
		@(negedge clk_sys);
		dl_i.wr = 1'b0;
		end_download();
		#1;
		check_value({name, " core reset off"}, 0, 32'(core_reset_o));
		for (int w = 0; w < 6; w++) begin
			nib = 4'($random(seed));
			cpu_i = '{addr: {12'hFDD, nib}, rnw: 1'b0, cs_ram_n: 1'b1, cs0_n: 1'b1,
				cs1_n: 1'b1, cs_io_n: 1'b0};
			cpu_ce_i = 1'b1;
			@(negedge clk_sys);
			cpu_i.cs_io_n = 1'b1;
			@(negedge clk_sys);
			cpu_ce_i = 1'b0;
			cpu_i.rnw = 1'b1;
			if (plus4) bank = nib;
			for (int r = 0; r < 40; r++) begin
				cpu_i.addr = 16'($random(seed));
				if (($random(seed) & 3) == 0) cpu_i.addr[15:8] = 8'hFC;
				nib = 4'($random(seed));
				cpu_i.cs_ram_n = nib[1:0] != 2'd0;
				cpu_i.cs0_n = nib[1:0] != 2'd1;
				cpu_i.cs1_n = nib[1:0] != 2'd2;
				#1;
				check_value({name, " source"}, 32'(expect_src(cpu_i, bank, lo, hi)),
					32'(rom_src_o));
				@(negedge clk_sys);
			end
		end
		cpu_i.cs_ram_n = 1'b1;
		cpu_i.cs0_n = 1'b1;
		cpu_i.cs1_n = 1'b1;
		report_test(name, e);
	endtask

	task automatic tape_download(input string name, input int n,
		output logic [7:0] bytes [$]);
		logic [7:0] b;
		bytes.delete();
		fifo_q.delete();
		for (int i = 0; i < n; i++) begin
			b = 8'($random(seed));
			bytes.push_back(b);
			send_byte(name, IDX_TAP, 25'(i), b);
		end
		end_download();
	endtask

	task automatic fifo_check(input string name, input logic [7:0] bytes [$],
		input int limit, input logic toggles);
		int t;
		t = 0;
		while (fifo_q.size() < bytes.size() && t < limit) begin
			if (toggles && ($random(seed) & 31) == 0) begin
				press_button();
				cycles(1 + ($random(seed) & 15));
				press_button();
			end else begin
				@(negedge clk_sys);
			end
			t++;
		end
		full_rand = 1'b0;
		fifo_full_i = 1'b0;
		cycles(20);
		if (fifo_q.size() != bytes.size()) begin
			$display("%s: FIFO got %0d bytes, %0d were stored", name, fifo_q.size(),
				bytes.size());
			errors++;
		end else begin
			for (int i = 0; i < bytes.size(); i++) begin
				check_value({name, " byte"}, 32'(bytes[i]), 32'(fifo_q[i]));
			end
		end
	endtask

	task automatic tape_test(input string name);
		int e;
		int restart_before;
		logic [7:0] bytes [$];
		e = errors;
		restart_before = restart_cnt;
		tape_download(name, 10 + ($random(seed) & 32'h7fff) % 51, bytes);
		check_value({name, " restart seen"}, 1, 32'(restart_cnt > restart_before));
		check_value({name, " restart idle"}, 0, 32'(tape_restart_o));
		fifo_check(name, bytes, 800, 1'b0);
		// Whole image played, nothing left loaded
		for (int i = 0; i < 16; i++) begin
			check_value({name, " LED idle"}, 0, 32'(tape_led_o));
			@(negedge clk_sys);
		end
		report_test(name, e);
	endtask

	task automatic flow_test(input string name);
		int e;
		int rd_before;
		int full_before;
		logic [7:0] bytes [$];
		e = errors;
		tape_download(name, 10 + ($random(seed) & 32'h7fff) % 51, bytes);
		full_before = full_reads;
		full_rand = 1'b1;
		fifo_check({name, " stalls"}, bytes, 2500, 1'b1);
		check_value({name, " reads while full"}, 32'(full_before), 32'(full_reads));
		// Empty FIFO at the end of the download keeps the tape stopped
		fifo_empty_i = 1'b1;
		tape_download(name, 10 + ($random(seed) & 32'h7fff) % 51, bytes);
		rd_before = rd_cnt;
		cycles(40);
		check_value({name, " reads while empty"}, 32'(rd_before), 32'(rd_cnt));
		check_value({name, " bytes while empty"}, 0, 32'(fifo_q.size()));
		fifo_empty_i = 1'b0;
		press_button();
		fifo_check({name, " resume"}, bytes, 800, 1'b0);
		report_test(name, e);
	endtask

	initial begin
		reset = 1'b1;
		model_plus4_i = 1'b1;
		pal_i = 1'b1;
		play_btn_i = 1'b0;
		cpu_ce_i = 1'b0;
		cpu_i = '{addr: 16'h0, rnw: 1'b1, cs_ram_n: 1'b1, cs0_n: 1'b1, cs1_n: 1'b1,
			cs_io_n: 1'b1};
		dl_i = '0;
		mem_ready_i = 1'b0;
		mem_data_i = 8'h0;
		fifo_full_i = 1'b0;
		fifo_empty_i = 1'b0;

		apply_reset(1'b1, 1'b1);
		drive_test("drive enable PAL", 1'b1);
		prg_test("PRG load Plus-4");
		bank_test("bank map Plus-4", 1'b1);
		tape_test("tape replay Plus-4");
		flow_test("tape flow Plus-4");

		apply_reset(1'b0, 1'b0);
		drive_test("drive enable NTSC", 1'b0);
		prg_test("PRG load C16");
		bank_test("bank map C16", 1'b0);
		tape_test("tape replay C16");
		flow_test("tape flow C16");

		$display("tests %0d, failed %0d, check errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/c16_glue_pkg.sv
logic/prg_loader.sv
logic/rom_bank_map.sv
logic/tape_streamer.sv
logic/drive_clock_enable.sv
logic/c16_glue_top.sv
test/tb_c16_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_c16_glue -o tb_c16_glue

output=$(./obj_dir/tb_c16_glue)
echo "$output"

echo "$output" | grep -q "Simulation finished: PASS"
